/* hw/mem_cfg_pkg.sv */
`default_nettype none

package mem_cfg_pkg;

   // ----------------------------------------
   // Line geometry
   // ----------------------------------------

   localparam int line_width = 32;                    // One word per line.
   localparam int addr_size = 12;                     // Width of a byte address.
   localparam int line_bytes = line_width / 8;
   localparam int lines = 256;
   localparam int line_addr_size = $clog2(lines);

   // Byte offset bits inside a line, dropped when decoding the index.
   localparam int offset_bits = $clog2(line_bytes);

   // The full index can point past the last line, so it is wider than a line address.
   localparam int index_size = addr_size - offset_bits;

   // ----------------------------------------
   // Timing
   // ----------------------------------------

   localparam int latency = 3;                        // Request to response, in cycles.

   // The access stage takes one cycle, the response pipeline takes the rest.
   localparam int pipe_depth = latency - 1;

endpackage

`default_nettype wire

/* hw/mem_if_pkg.sv */
`default_nettype none

package mem_if_pkg;

   import mem_cfg_pkg::*;

   // ----------------------------------------
   // Encodings
   // ----------------------------------------

   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

   typedef enum logic [1:0] {
      reg_protect_limit = 2'd0,
      reg_err_count     = 2'd1,
      reg_last_bad_addr = 2'd2
   } csr_reg_e;

   // ----------------------------------------
   // Request and response bundles
   // ----------------------------------------

   // Port 1 ignores op and wdata.
   typedef struct packed {
      mem_op_e                op;
      logic [addr_size-1:0]   addr;
      logic [line_width-1:0]  wdata;
   } mem_req_t;

   typedef struct packed {
      logic [line_width-1:0]  data;
      logic                   err;     // Bad address or refused write.
   } mem_rsp_t;

   typedef struct packed {
      csr_reg_e               register;
      logic                   write;
      logic [line_width-1:0]  wdata;
   } csr_req_t;

endpackage

`default_nettype wire

/* hw/line_array.sv */
`default_nettype none

module line_array (
   input  wire                                    clk,
   input  wire                                    reset,
   input  wire                                    wr_en,
   input  wire  [mem_cfg_pkg::line_addr_size-1:0] wr_line,
   input  wire  [mem_cfg_pkg::line_width-1:0]     wr_data,
   input  wire  [mem_cfg_pkg::line_addr_size-1:0] rd1_line,
   input  wire  [mem_cfg_pkg::line_addr_size-1:0] rd2_line,
   output logic [mem_cfg_pkg::line_width-1:0]     rd1_data,
   output logic [mem_cfg_pkg::line_width-1:0]     rd2_data
);

   import mem_cfg_pkg::*;

   logic [line_width-1:0] mem [lines];

   // ----------------------------------------
   // Write port
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (!reset) begin
         for (int i = 0; i < lines; i++) begin
            mem[i] <= '0;                        // Contents start at zero.
         end
      end else if (wr_en) begin
         mem[wr_line] <= wr_data;
      end
   end

   // ----------------------------------------
   // Read ports
   // ----------------------------------------

   // Both reads see the value held before a write on the same edge.
   always_ff @(posedge clk) begin
      rd1_data <= mem[rd1_line];
      rd2_data <= mem[rd2_line];
   end

endmodule

`default_nettype wire

/* hw/port_access.sv */
`default_nettype none

module port_access (
   input  wire                                    clk,
   input  wire                                    reset,
   input  wire                                    p1_req_valid,
   input  wire  mem_if_pkg::mem_req_t             p1_req,
   input  wire                                    p2_req_valid,
   input  wire  mem_if_pkg::mem_req_t             p2_req,
   input  wire  [mem_cfg_pkg::line_width-1:0]     protect_limit,
   input  wire  [mem_cfg_pkg::line_width-1:0]     rd1_data,
   input  wire  [mem_cfg_pkg::line_width-1:0]     rd2_data,
   output logic                                   wr_en,
   output logic [mem_cfg_pkg::line_addr_size-1:0] wr_line,
   output logic [mem_cfg_pkg::line_width-1:0]     wr_data,
   output logic [mem_cfg_pkg::line_addr_size-1:0] rd1_line,
   output logic [mem_cfg_pkg::line_addr_size-1:0] rd2_line,
   output mem_if_pkg::mem_rsp_t                   p1_stage,
   output logic                                   p1_stage_valid,
   output mem_if_pkg::mem_rsp_t                   p2_stage,
   output logic                                   p2_stage_valid,
   output logic                                   err_event,
   output logic [1:0]                             err_count_inc,
   output logic [mem_cfg_pkg::addr_size-1:0]      err_addr
);

   import mem_cfg_pkg::*;
   import mem_if_pkg::*;

   logic [index_size-1:0] p1_index;
   logic [index_size-1:0] p2_index;
   logic                  p1_range_err;
   logic                  p2_range_err;
   logic                  p2_is_write;
   logic                  p2_prot_err;
   logic                  p1_fault;
   logic                  p2_fault;
   logic                  p1_fwd;
   logic                  p1_err_q;
   logic                  p1_fwd_q;
   logic                  p2_err_q;
   logic                  p2_write_q;
   logic [line_width-1:0] wdata_q;

   // ----------------------------------------
   // Decode and checks
   // ----------------------------------------

   assign p1_index = p1_req.addr[addr_size-1:offset_bits];
   assign p2_index = p2_req.addr[addr_size-1:offset_bits];
   assign p1_range_err = p1_index >= index_size'(lines);
   assign p2_range_err = p2_index >= index_size'(lines);
   assign p2_is_write = p2_req.op == op_write;
   assign p2_prot_err = p2_is_write && (line_width'(p2_index) < protect_limit);

   assign p1_fault = p1_req_valid && p1_range_err;
   assign p2_fault = p2_req_valid && (p2_range_err || p2_prot_err);

   assign wr_en = p2_req_valid && p2_is_write && !p2_range_err && !p2_prot_err;
   assign wr_line = p2_index[line_addr_size-1:0];
   assign wr_data = p2_req.wdata;
   assign rd1_line = p1_index[line_addr_size-1:0];
   assign rd2_line = p2_index[line_addr_size-1:0];

   assign p1_fwd = wr_en && (p1_index == p2_index);  // Port 1 sees the new data.

   assign err_event = p1_fault || p2_fault;
   assign err_count_inc = {1'b0, p1_fault} + {1'b0, p2_fault};
   assign err_addr = p2_fault ? p2_req.addr : p1_req.addr;  // Port 2 wins a tie.

   // ----------------------------------------
   // Stage aligned with the array read
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (!reset) begin
         p1_stage_valid <= 1'b0;
         p2_stage_valid <= 1'b0;
      end else begin
         p1_stage_valid <= p1_req_valid;
         p2_stage_valid <= p2_req_valid;
      end
   end

   always_ff @(posedge clk) begin
      p1_err_q   <= p1_range_err;
      p1_fwd_q   <= p1_fwd;
      p2_err_q   <= p2_range_err || p2_prot_err;
      p2_write_q <= p2_is_write;
      wdata_q    <= p2_req.wdata;                   // Shared by both forwarding paths.
   end

   always_comb begin
      p1_stage.err = p1_err_q;
      p1_stage.data = p1_err_q ? '0 : (p1_fwd_q ? wdata_q : rd1_data);
      p2_stage.err = p2_err_q;
      p2_stage.data = p2_err_q ? '0 : (p2_write_q ? wdata_q : rd2_data);
   end

endmodule

`default_nettype wire

/* hw/latency_pipe.sv */
`default_nettype none

module latency_pipe (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   in_valid,
   input  wire  mem_if_pkg::mem_rsp_t in_rsp,
   output logic                  out_valid,
   output mem_if_pkg::mem_rsp_t  out_rsp
);

   import mem_cfg_pkg::*;
   import mem_if_pkg::*;

   logic [pipe_depth-1:0] valid_q;
   mem_rsp_t              rsp_q [pipe_depth];

   always_ff @(posedge clk) begin
      if (!reset) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= in_valid;
         for (int i = 1; i < pipe_depth; i++) begin
            valid_q[i] <= valid_q[i-1];
         end
      end
   end

   // Each stage holds its own response, so back-to-back requests all fit.
   always_ff @(posedge clk) begin
      rsp_q[0] <= in_rsp;
      for (int i = 1; i < pipe_depth; i++) begin
         rsp_q[i] <= rsp_q[i-1];
      end
   end

   assign out_valid = valid_q[pipe_depth-1];
   assign out_rsp = rsp_q[pipe_depth-1];

endmodule

`default_nettype wire

/* hw/mem_csr.sv */
`default_nettype none

module mem_csr (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                csr_req_valid,
   input  wire  mem_if_pkg::csr_req_t         csr_req,
   input  wire                                err_event,
   input  wire  [1:0]                         err_count_inc,
   input  wire  [mem_cfg_pkg::addr_size-1:0]  err_addr,
   output logic                               csr_rsp_valid,
   output logic [mem_cfg_pkg::line_width-1:0] csr_rdata,
   output logic [mem_cfg_pkg::line_width-1:0] protect_limit
);

   import mem_cfg_pkg::*;
   import mem_if_pkg::*;

   logic [line_width-1:0] protect_q;
   logic [line_width-1:0] err_count_q;
   logic [addr_size-1:0]  last_bad_q;
   logic [line_width:0]   count_sum;
   logic [line_width-1:0] protect_next;
   logic [line_width-1:0] count_next;
   logic [line_width-1:0] rdata_next;
   logic                  wr_protect;
   logic                  wr_count;

   // ----------------------------------------
   // Next register values
   // ----------------------------------------

   assign wr_protect = csr_req_valid && csr_req.write && csr_req.register == reg_protect_limit;
   assign wr_count = csr_req_valid && csr_req.write && csr_req.register == reg_err_count;
   assign count_sum = {1'b0, err_count_q} + (line_width + 1)'(err_count_inc);
   assign protect_next = wr_protect ? csr_req.wdata : protect_q;

   always_comb begin
      if (wr_count) begin
         count_next = '0;                              // A write clears the count.
      end else if (err_event) begin
         count_next = count_sum[line_width] ? '1 : count_sum[line_width-1:0];
      end else begin
         count_next = err_count_q;
      end
   end

   // Writes answer with the value they leave behind.
   always_comb begin
      case (csr_req.register)
         reg_protect_limit: rdata_next = protect_next;
         reg_err_count:     rdata_next = csr_req.write ? count_next : err_count_q;
         reg_last_bad_addr: rdata_next = line_width'(last_bad_q);
         default:           rdata_next = '0;
      endcase
   end

   // ----------------------------------------
   // Registers
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (!reset) begin
         protect_q     <= '0;
         err_count_q   <= '0;
         last_bad_q    <= '0;
         csr_rsp_valid <= 1'b0;
      end else begin
         protect_q     <= protect_next;
         err_count_q   <= count_next;
         csr_rsp_valid <= csr_req_valid;
         if (err_event) begin
            last_bad_q <= err_addr;
         end
      end
   end

   always_ff @(posedge clk) begin
      csr_rdata <= rdata_next;
   end

   assign protect_limit = protect_q;

endmodule

`default_nettype wire

/* hw/mem_top.sv */
`default_nettype none

module mem_top (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                p1_req_valid,
   input  wire  mem_if_pkg::mem_req_t         p1_req,
   output logic                               p1_rsp_valid,
   output mem_if_pkg::mem_rsp_t               p1_rsp,
   input  wire                                p2_req_valid,
   input  wire  mem_if_pkg::mem_req_t         p2_req,
   output logic                               p2_rsp_valid,
   output mem_if_pkg::mem_rsp_t               p2_rsp,
   input  wire                                csr_req_valid,
   input  wire  mem_if_pkg::csr_req_t         csr_req,
   output logic                               csr_rsp_valid,
   output logic [mem_cfg_pkg::line_width-1:0] csr_rdata
);

   import mem_cfg_pkg::*;
   import mem_if_pkg::*;

   logic                      wr_en;
   logic [line_addr_size-1:0] wr_line;
   logic [line_width-1:0]     wr_data;
   logic [line_addr_size-1:0] rd1_line;
   logic [line_addr_size-1:0] rd2_line;
   logic [line_width-1:0]     rd1_data;
   logic [line_width-1:0]     rd2_data;
   mem_rsp_t                  p1_stage;
   logic                      p1_stage_valid;
   mem_rsp_t                  p2_stage;
   logic                      p2_stage_valid;
   logic                      err_event;
   logic [1:0]                err_count_inc;
   logic [addr_size-1:0]      err_addr;
   logic [line_width-1:0]     protect_limit;

   port_access i_access (
      .clk, .reset,
      .p1_req_valid, .p1_req, .p2_req_valid, .p2_req,
      .protect_limit, .rd1_data, .rd2_data,
      .wr_en, .wr_line, .wr_data, .rd1_line, .rd2_line,
      .p1_stage, .p1_stage_valid, .p2_stage, .p2_stage_valid,
      .err_event, .err_count_inc, .err_addr
   );

   line_array i_array (
      .clk, .reset,
      .wr_en, .wr_line, .wr_data,
      .rd1_line, .rd2_line, .rd1_data, .rd2_data
   );

   latency_pipe i_p1_pipe (
      .clk, .reset,
      .in_valid  (p1_stage_valid),
      .in_rsp    (p1_stage),
      .out_valid (p1_rsp_valid),
      .out_rsp   (p1_rsp)
   );

   latency_pipe i_p2_pipe (
      .clk, .reset,
      .in_valid  (p2_stage_valid),
      .in_rsp    (p2_stage),
      .out_valid (p2_rsp_valid),
      .out_rsp   (p2_rsp)
   );

   mem_csr i_csr (
      .clk, .reset,
      .csr_req_valid, .csr_req,
      .err_event, .err_count_inc, .err_addr,
      .csr_rsp_valid, .csr_rdata, .protect_limit
   );

endmodule

`default_nettype wire

/* verif/mem_tb.sv */
`default_nettype none

module mem_tb;

   import mem_cfg_pkg::*;
   import mem_if_pkg::*;

   localparam int reset_cycles = 16;
   localparam int n_reset_reads = 20;
   localparam int n_traffic = 40;
   localparam int n_fill_reads = 16;
   localparam int n_forward = 4;
   localparam int n_protect = 8;
   localparam int test_cycles = reset_cycles + n_reset_reads + n_traffic + n_fill_reads
                                + 2 * n_forward + 6 + 2 * n_protect + 7 + 5 * (latency + 1);
   localparam int timeout_limit = test_cycles + 100;

   typedef struct packed {
      int       due;
      mem_rsp_t rsp;
   } exp_rsp_t;

   typedef struct packed {
      int          due;
      logic [31:0] rdata;
   } exp_csr_t;

   logic                  clk;
   logic                  reset;
   logic                  p1_req_valid;
   mem_req_t              p1_req;
   logic                  p1_rsp_valid;
   mem_rsp_t              p1_rsp;
   logic                  p2_req_valid;
   mem_req_t              p2_req;
   logic                  p2_rsp_valid;
   mem_rsp_t              p2_rsp;
   logic                  csr_req_valid;
   csr_req_t              csr_req;
   logic                  csr_rsp_valid;
   logic [line_width-1:0] csr_rdata;

   logic [31:0]           lfsr = 32'hfeef;
   int                    cycle = 0;
   int                    checks = 0;
   int                    errors = 0;
   int                    err_mark = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;

   // Reference state.
   logic [line_width-1:0] shadow [lines];
   logic [31:0]           ref_protect = '0;
   logic [31:0]           ref_count = '0;
   logic [addr_size-1:0]  ref_last_bad = '0;
   exp_rsp_t              p1_q [$];
   exp_rsp_t              p2_q [$];
   exp_csr_t              csr_q [$];

   mem_top i_dut (
      .clk, .reset,
      .p1_req_valid, .p1_req, .p1_rsp_valid, .p1_rsp,
      .p2_req_valid, .p2_req, .p2_rsp_valid, .p2_rsp,
      .csr_req_valid, .csr_req, .csr_rsp_valid, .csr_rdata
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic mem_req_t make_req(input mem_op_e op, input int addr,
                                         input logic [31:0] wdata);
      mem_req_t r;
      r.op = op;
      r.addr = addr_size'(addr);
      r.wdata = wdata;
      return r;
   endfunction

   function automatic csr_req_t make_csr(input csr_reg_e sel, input logic wr,
                                         input logic [31:0] wdata);
      csr_req_t r;
      r.register = sel;
      r.write = wr;
      r.wdata = wdata;
      return r;
   endfunction

   // Computes the responses of one request cycle and updates the shadow state.
   function void ref_access(input logic v1, input mem_req_t r1, input logic v2,
                            input mem_req_t r2, input logic vc, input csr_req_t rc);
      int          idx1;
      int          idx2;
      logic        f1;
      logic        f2;
      logic        wr_ok;
      logic [32:0] sum;
      exp_rsp_t    e;
      exp_csr_t    ec;
      idx1 = int'(r1.addr) / line_bytes;
      idx2 = int'(r2.addr) / line_bytes;
      f1 = v1 && idx1 >= lines;
      f2 = v2 && (idx2 >= lines || (r2.op == op_write && idx2 < ref_protect));
      wr_ok = v2 && r2.op == op_write && !f2;
      if (v1) begin
         e.due = cycle + latency;
         e.rsp.err = f1;
         if (f1) e.rsp.data = '0;
         else if (wr_ok && idx1 == idx2) e.rsp.data = r2.wdata;   // New data wins.
         else e.rsp.data = shadow[idx1];
         p1_q.push_back(e);
      end
      if (v2) begin
         e.due = cycle + latency;
         e.rsp.err = f2;
         if (f2) e.rsp.data = '0;
         else if (r2.op == op_write) e.rsp.data = r2.wdata;
         else e.rsp.data = shadow[idx2];
         p2_q.push_back(e);
      end
      if (vc) begin
         ec.due = cycle + 1;
         case (rc.register)
            reg_protect_limit: ec.rdata = rc.write ? rc.wdata : ref_protect;
            reg_err_count:     ec.rdata = rc.write ? '0 : ref_count;
            default:           ec.rdata = 32'(ref_last_bad);
         endcase
         csr_q.push_back(ec);
      end
      if (wr_ok) shadow[idx2] = r2.wdata;
      if (vc && rc.write && rc.register == reg_err_count) begin
         ref_count = '0;
      end else begin
         sum = {1'b0, ref_count} + 33'(f1) + 33'(f2);
         ref_count = sum[32] ? '1 : sum[31:0];            // Saturates.
      end
      if (f2) ref_last_bad = r2.addr;
      else if (f1) ref_last_bad = r1.addr;
      if (vc && rc.write && rc.register == reg_protect_limit) ref_protect = rc.wdata;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("%s at cycle %0d", what, cycle);
   endtask

   task automatic compare_rsp(input string name, input mem_rsp_t got, input exp_rsp_t exp);
      check_value({name, ".data"}, got.data, exp.rsp.data);
      check_value({name, ".err"}, 32'(got.err), 32'(exp.rsp.err));
      if (cycle != exp.due) note_failure({name, " arrived off its fixed latency"});
   endtask

   task automatic issue(input logic v1, input mem_req_t r1, input logic v2,
                        input mem_req_t r2, input logic vc, input csr_req_t rc);
      p1_req_valid = v1;
      p1_req = r1;
      p2_req_valid = v2;
      p2_req = r2;
      csr_req_valid = vc;
      csr_req = rc;
      ref_access(v1, r1, v2, r2, vc, rc);
      @(posedge clk);
      #10;
   endtask

   task automatic idle_cycle();
      issue(1'b0, '0, 1'b0, '0, 1'b0, '0);
   endtask

   task automatic finish_test(input string name);
      int errs;
      while (p1_q.size() + p2_q.size() + csr_q.size() != 0) idle_cycle();
      errs = errors - err_mark;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
      err_mark = errors;
   endtask

   // ----------------------------------------
   // Compare process
   // ----------------------------------------

   always @(negedge clk) begin
      if (reset) begin
         if (p1_rsp_valid) begin
            if (p1_q.size() == 0) note_failure("port 1 responded without a request");
            else compare_rsp("p1_rsp", p1_rsp, p1_q.pop_front());
         end else if (p1_q.size() != 0 && p1_q[0].due <= cycle) begin
            note_failure("port 1 response missing");
            p1_q.delete(0);
         end
         if (p2_rsp_valid) begin
            if (p2_q.size() == 0) note_failure("port 2 responded without a request");
            else compare_rsp("p2_rsp", p2_rsp, p2_q.pop_front());
         end else if (p2_q.size() != 0 && p2_q[0].due <= cycle) begin
            note_failure("port 2 response missing");
            p2_q.delete(0);
         end
         if (csr_rsp_valid) begin
            if (csr_q.size() == 0) begin
               note_failure("register port responded without a request");
            end else begin
               check_value("csr_rdata", csr_rdata, csr_q[0].rdata);
               if (cycle != csr_q[0].due) note_failure("register response off by a cycle");
               csr_q.delete(0);
            end
         end else if (csr_q.size() != 0 && csr_q[0].due <= cycle) begin
            note_failure("register response missing");
            csr_q.delete(0);
         end
      end
   end

   initial begin
      while (cycle < timeout_limit) @(posedge clk);
      $display("run did not finish within %0d cycles", timeout_limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ----------------------------------------
   // Tests
   // ----------------------------------------

   initial begin
      int          line;
      logic [31:0] data;
      reset = 1'b0;
      p1_req_valid = 1'b0;
      p1_req = '0;
      p2_req_valid = 1'b0;
      p2_req = '0;
      csr_req_valid = 1'b0;
      csr_req = '0;
      for (int i = 0; i < lines; i++) shadow[i] = '0;
      repeat (reset_cycles) @(posedge clk);
      #10;
      reset = 1'b1;

      for (int i = 0; i < n_reset_reads; i++) begin
         issue(1'b1, make_req(op_read, int'(rand_bits(10)), '0),
               1'b1, make_req(op_read, int'(rand_bits(10)), '0), 1'b0, '0);
      end
      finish_test("reads after reset");

      // A small window of lines so that reads hit earlier writes.
      for (int i = 0; i < n_traffic; i++) begin
         issue(1'b0, '0, 1'b1, make_req(rand_bits(1) != 0 ? op_write : op_read,
               int'(rand_bits(4)) * line_bytes, rand_bits(32)), 1'b0, '0);
      end
      for (int i = 0; i < n_fill_reads; i++) begin
         issue(1'b1, make_req(op_read, i * line_bytes + int'(rand_bits(2)), '0),
               1'b0, '0, 1'b0, '0);
      end
      finish_test("random port 2 traffic");

      for (int i = 0; i < n_forward; i++) begin
         line = int'(rand_bits(8));
         data = rand_bits(32);
         issue(1'b1, make_req(op_read, line * line_bytes, '0),
               1'b1, make_req(op_write, line * line_bytes, data), 1'b0, '0);
         issue(1'b1, make_req(op_read, line * line_bytes, '0), 1'b0, '0, 1'b0, '0);
      end
      finish_test("same cycle forwarding");

      line = int'(rand_bits(8));
      issue(1'b1, make_req(op_read, 1024 + int'(rand_bits(11)), '0),
            1'b1, make_req(op_write, (lines + line) * line_bytes, rand_bits(32)), 1'b0, '0);
      issue(1'b1, make_req(op_read, line * line_bytes, '0), 1'b0, '0,
            1'b1, make_csr(reg_err_count, 1'b0, '0));
      issue(1'b0, '0, 1'b1, make_req(op_read, 4092, '0),
            1'b1, make_csr(reg_last_bad_addr, 1'b0, '0));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_err_count, 1'b0, '0));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_last_bad_addr, 1'b1, 32'hffff));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_last_bad_addr, 1'b0, '0));
      finish_test("bad addresses");

      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_protect_limit, 1'b1, 32'd64));
      for (int i = 0; i < n_protect; i++) begin
         line = int'(rand_bits(6));
         issue(1'b1, make_req(op_read, line * line_bytes, '0),
               1'b1, make_req(op_write, line * line_bytes, rand_bits(32)), 1'b0, '0);
         issue(1'b1, make_req(op_read, line * line_bytes, '0), 1'b1,
               make_req(op_write, (64 + int'(rand_bits(7))) * line_bytes, rand_bits(32)),
               1'b0, '0);
      end
      issue(1'b0, '0, 1'b1, make_req(op_write, 63 * line_bytes, rand_bits(32)), 1'b0, '0);
      issue(1'b0, '0, 1'b1, make_req(op_write, 64 * line_bytes, rand_bits(32)), 1'b0, '0);
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_err_count, 1'b0, '0));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_err_count, 1'b1, 32'h1234));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_err_count, 1'b0, '0));
      issue(1'b0, '0, 1'b0, '0, 1'b1, make_csr(reg_protect_limit, 1'b1, '0));
      finish_test("write protection");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
hw/mem_cfg_pkg.sv
hw/mem_if_pkg.sv
hw/line_array.sv
hw/port_access.sv
hw/latency_pipe.sv
hw/mem_csr.sv
hw/mem_top.sv
verif/mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the memory testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f vlog.f --top-module mem_tb -Mdir "$build_dir" -o mem_sim
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

"./$build_dir/mem_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
   exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$log_file"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
